/* src.f */
+incdir+include
+incdir+sim
verilog/aes_pkg.sv
verilog/aes_key_expander.sv
verilog/aes_round_key_store.sv
verilog/aes_round_engine.sv
verilog/aes_core.sv
sim/tb_aes_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS := --lint-only --timing --timescale 1ns/1ps
TOP       := tb_aes_core
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

run: build
	./$(SIM)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/aes_ref_model.svh */
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// software AES-128 over byte arrays, byte 0 first as in FIPS-197
function automatic aes_block_t ref_encrypt(input aes_block_t k, input aes_block_t p);
    logic [7:0] w [0:175];  // 11 round keys, 16 bytes each
    logic [7:0] s [0:15];
    logic [7:0] t [0:15];
    logic [7:0] tmp [0:3];
    logic [7:0] rc;
    logic [7:0] a0, a1, a2, a3, col_xor;
    aes_block_t res;
    rc = 8'h01;
    for (int i = 0; i < 16; i++) begin
        w[i] = k.bytes[i];
    end
    for (int i = 4; i < 44; i++) begin
        for (int j = 0; j < 4; j++) begin
            tmp[j] = w[4*i - 4 + j];
        end
        if (i % 4 == 0) begin
            tmp[0] = sbox(w[4*i - 3]) ^ rc;  // rotate, substitute, rcon
            tmp[1] = sbox(w[4*i - 2]);
            tmp[2] = sbox(w[4*i - 1]);
            tmp[3] = sbox(w[4*i - 4]);
            rc = xtime(rc);
        end
        for (int j = 0; j < 4; j++) begin
            w[4*i + j] = w[4*i - 16 + j] ^ tmp[j];
        end
    end
    for (int i = 0; i < 16; i++) begin
        s[i] = p.bytes[i] ^ w[i];
    end
    for (int r = 1; r <= 10; r++) begin
        for (int i = 0; i < 16; i++) begin
            t[i] = sbox(s[(i + 4*(i % 4)) % 16]);  // sub bytes and shift rows
        end
        if (r < 10) begin
            for (int c = 0; c < 4; c++) begin
                a0 = t[4*c];
                a1 = t[4*c + 1];
                a2 = t[4*c + 2];
                a3 = t[4*c + 3];
                col_xor = a0 ^ a1 ^ a2 ^ a3;
                t[4*c]     = a0 ^ col_xor ^ xtime(a0 ^ a1);
                t[4*c + 1] = a1 ^ col_xor ^ xtime(a1 ^ a2);
                t[4*c + 2] = a2 ^ col_xor ^ xtime(a2 ^ a3);
                t[4*c + 3] = a3 ^ col_xor ^ xtime(a3 ^ a0);
            end
        end
        for (int i = 0; i < 16; i++) begin
            s[i] = t[i] ^ w[16*r + i];
        end
    end
    for (int i = 0; i < 16; i++) begin
        res.bytes[i] = s[i];
    end
    return res;
endfunction

`endif

/* sim/tb_aes_core.sv */
`default_nettype none

module tb_aes_core
    import aes_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD       = 100;
    localparam int DRIVE_DELAY      = 10;
    localparam int RESET_CYCLES     = 4;
    localparam int LATENCY          = 11;
    localparam int NUM_RANDOM       = 30;
    localparam int NUM_BLOCKS       = NUM_RANDOM + 3;  // two vectors plus the stray start block
    localparam int CYCLES_PER_BLOCK = 20;

    localparam aes_block_t KEY_A = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_block_t PT_A  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_block_t CT_A  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam aes_block_t KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aes_block_t PT_B  = 128'h3243f6a8885a308d313198a2e0370734;
    localparam aes_block_t CT_B  = 128'h3925841d02dc09fbdc118597196a0b32;

    logic       clk;
    logic       rst;
    logic       start;
    aes_block_t plaintext;
    aes_block_t key;
    aes_block_t ciphertext;
    logic       done;
    logic       busy;

    aes_block_t exp_q[$];   // expected ciphertexts in issue order
    int         edge_q[$];  // edge count when each start was sampled
    int         edge_cnt = 0;
    int         blocks_done = 0;
    integer     seed;

    `include "aes_ref_model.svh"

    aes_core u_dut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .plaintext  (plaintext),
        .key        (key),
        .ciphertext (ciphertext),
        .done       (done),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_block(input string name, input aes_block_t actual,
                               input aes_block_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("FAILED at %0d ns: %s expected %h, got %h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("FAILED at %0d ns: %s expected %b, got %b",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_cycles(input string name, input int actual, input int expected);
        if (actual != expected) begin
            report_failure($sformatf("FAILED at %0d ns: %s expected %0d, got %0d",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic random_block(output aes_block_t b);
        for (int c = 0; c < 4; c++) begin
            b.cols[c] = $random(seed);
        end
    endtask

    // one start pulse, sampled on the second edge
    task automatic issue_block(input aes_block_t k, input aes_block_t p,
                               input aes_block_t exp_ct);
        @(posedge clk);
        #DRIVE_DELAY;
        key       = k;
        plaintext = p;
        start     = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        exp_q.push_back(exp_ct);
        edge_q.push_back(edge_cnt);
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            waited++;
            if (waited > LATENCY + 2) begin
                report_failure("done did not arrive after start");
            end else begin
                @(negedge clk);
            end
        end
    endtask

    initial begin : compare
        aes_block_t exp_ct;
        int         exp_edge;
        logic       prev_done;
        prev_done = 1'b0;
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (prev_done) begin
                check_bit("done", done, 1'b0);  // one cycle only
                check_bit("busy", busy, 1'b0);
            end else if (done === 1'b1) begin
                if (exp_q.size() == 0) begin
                    report_failure("done pulsed with no block pending");
                end else begin
                    exp_ct   = exp_q.pop_front();
                    exp_edge = edge_q.pop_front();
                    check_bit("busy", busy, 1'b1);
                    check_cycles("done latency", edge_cnt - exp_edge, LATENCY);
                    check_block("ciphertext", ciphertext, exp_ct);
                    blocks_done++;
                end
            end else begin
                check_bit("done", done, 1'b0);
                check_bit("busy", busy, exp_q.size() != 0);
            end
            prev_done = (done === 1'b1);
        end
    end

    initial begin : stimulus
        aes_block_t k;
        aes_block_t p;
        seed      = 6371;
        rst       = 1'b1;
        start     = 1'b0;
        key       = '0;
        plaintext = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        repeat (3) begin
            @(negedge clk);
            check_bit("done", done, 1'b0);
            check_bit("busy", busy, 1'b0);
            check_block("ciphertext", ciphertext, '0);
        end

        check_block("reference ciphertext", ref_encrypt(KEY_A, PT_A), CT_A);
        issue_block(KEY_A, PT_A, CT_A);
        wait_done();
        check_block("reference ciphertext", ref_encrypt(KEY_B, PT_B), CT_B);
        issue_block(KEY_B, PT_B, CT_B);
        wait_done();

        // stray start mid-block with other data
        issue_block(KEY_A, PT_B, ref_encrypt(KEY_A, PT_B));
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        key       = KEY_B;
        plaintext = PT_A;
        start     = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        check_bit("busy", busy, 1'b1);
        wait_done();
        repeat (2 * LATENCY) @(negedge clk);  // a second done would show up here

        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_block(k);
            random_block(p);
            issue_block(k, p, ref_encrypt(k, p));
            wait_done();
        end

        repeat (3) @(negedge clk);
        if (blocks_done != NUM_BLOCKS) begin
            report_failure($sformatf("only %0d of %0d blocks completed",
                                     blocks_done, NUM_BLOCKS));
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

    initial begin : watchdog
        #((RESET_CYCLES + NUM_BLOCKS * CYCLES_PER_BLOCK) * CLK_PERIOD);
        report_failure("timeout, done never arrived");
    end

endmodule

`default_nettype wire

/* verilog/aes_core.sv */
`default_nettype none

module aes_core
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  aes_block_t plaintext,
    input  aes_block_t key,
    output aes_block_t ciphertext,
    output logic       done,
    output logic       busy
);

    logic           key_wr_en;
    aes_round_idx_t key_wr_idx;
    aes_block_t     key_wr_data;
    aes_round_idx_t key_rd_idx;
    aes_block_t     key_rd_data;

    aes_key_expander u_key_expander (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .key         (key),
        .key_wr_en   (key_wr_en),
        .key_wr_idx  (key_wr_idx),
        .key_wr_data (key_wr_data),
        .expanding   ()             // busy from the engine covers it
    );

    aes_round_key_store u_key_store (
        .clk         (clk),
        .key_wr_en   (key_wr_en),
        .key_wr_idx  (key_wr_idx),
        .key_wr_data (key_wr_data),
        .key_rd_idx  (key_rd_idx),
        .key_rd_data (key_rd_data)
    );

    aes_round_engine u_round_engine (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .plaintext   (plaintext),
        .key_rd_data (key_rd_data),
        .key_rd_idx  (key_rd_idx),
        .ciphertext  (ciphertext),
        .done        (done),
        .busy        (busy)
    );

endmodule

`default_nettype wire

/* verilog/aes_round_engine.sv */
`default_nettype none

module aes_round_engine
    import aes_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  aes_block_t     plaintext,
    input  aes_block_t     key_rd_data,
    output aes_round_idx_t key_rd_idx,
    output aes_block_t     ciphertext,
    output logic           done,
    output logic           busy
);

    aes_round_idx_t rnd;
    aes_block_t     state;
    aes_block_t     sb;
    aes_block_t     sr;
    aes_block_t     mc;
    aes_block_t     round_out;
    logic           last_round;

    function automatic logic [31:0] mix_column(input logic [31:0] col);
        logic [7:0] a0, a1, a2, a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            sb.bytes[i] = sbox(state.bytes[i]);
        end
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                sr.bytes[4*c + r] = sb.bytes[4*((c + r) % 4) + r];  // row r left by r
            end
            mc.cols[c] = mix_column(sr.cols[c]);
        end
    end

    assign last_round = (rnd == AES_NUM_ROUNDS);
    assign key_rd_idx = rnd;

    // round 0 is the plain key add
    assign round_out = (rnd == 4'd0) ? (state ^ key_rd_data)
                                     : ((last_round ? sr : mc) ^ key_rd_data);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            rnd        <= '0;
            ciphertext <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                rnd  <= '0;
            end else if (busy) begin
                rnd <= rnd + 4'd1;
                if (last_round) begin
                    ciphertext <= round_out;
                    done       <= 1'b1;
                end
                if (rnd == AES_NUM_KEYS) begin
                    busy <= 1'b0;  // high through the done cycle
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            state <= plaintext;
        end else if (busy && !done) begin
            state <= round_out;
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done);
    a_idle_after: assert property (@(posedge clk) disable iff (rst) done |=> !busy);

endmodule

`default_nettype wire

/* verilog/aes_round_key_store.sv */
`default_nettype none

module aes_round_key_store
    import aes_pkg::*;
(
    input  logic           clk,
    input  logic           key_wr_en,
    input  aes_round_idx_t key_wr_idx,
    input  aes_block_t     key_wr_data,
    input  aes_round_idx_t key_rd_idx,
    output aes_block_t     key_rd_data
);

    aes_block_t keys [AES_NUM_KEYS];

    always_ff @(posedge clk) begin
        if (key_wr_en) begin
            keys[key_wr_idx] <= key_wr_data;
        end
    end

    assign key_rd_data = keys[key_rd_idx];  // no read latency

    // index comes from the expander
    a_wr_in_range: assert property (
        @(posedge clk) key_wr_en |-> key_wr_idx < AES_NUM_KEYS
    );

endmodule

`default_nettype wire

/* verilog/aes_key_expander.sv */
`default_nettype none

module aes_key_expander
    import aes_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  aes_block_t     key,
    output logic           key_wr_en,
    output aes_round_idx_t key_wr_idx,
    output aes_block_t     key_wr_data,
    output logic           expanding
);

    aes_round_idx_t rnd;       // index of the key held in prev_key
    aes_block_t     prev_key;
    aes_block_t     next_key;
    logic [31:0]    temp;
    logic           load;

    assign load = start && !expanding;

    always_comb begin
        temp = sub_word(rot_word(prev_key.cols[3])) ^ {aes_rcon(rnd + 4'd1), 24'h0};
        next_key.cols[0] = prev_key.cols[0] ^ temp;
        next_key.cols[1] = prev_key.cols[1] ^ next_key.cols[0];
        next_key.cols[2] = prev_key.cols[2] ^ next_key.cols[1];
        next_key.cols[3] = prev_key.cols[3] ^ next_key.cols[2];
    end

    assign key_wr_en   = load || (expanding && rnd < AES_NUM_ROUNDS);
    assign key_wr_idx  = load ? 4'd0 : rnd + 4'd1;
    assign key_wr_data = load ? key : next_key;

    // stays active as long as the engine is busy so both drop start alike
    always_ff @(posedge clk) begin
        if (rst) begin
            expanding <= 1'b0;
            rnd       <= '0;
        end else if (load) begin
            expanding <= 1'b1;
            rnd       <= '0;
        end else if (expanding) begin
            rnd <= rnd + 4'd1;
            if (rnd == AES_NUM_KEYS) begin
                expanding <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_wr_en) begin
            prev_key <= key_wr_data;
        end
    end

    a_wr_idx_range: assert property (
        @(posedge clk) disable iff (rst) key_wr_en |-> key_wr_idx <= AES_NUM_ROUNDS
    );

endmodule

`default_nettype wire

/* verilog/aes_pkg.sv */
`default_nettype none

package aes_pkg;

    localparam int AES_BLOCK_BITS = 128;

    typedef logic [3:0] aes_round_idx_t;

    localparam aes_round_idx_t AES_NUM_ROUNDS = 4'd10;
    localparam aes_round_idx_t AES_NUM_KEYS   = 4'd11;

    typedef union packed {
        logic [0:AES_BLOCK_BITS/8-1][7:0]   bytes;  // byte 0 is the top byte
        logic [0:AES_BLOCK_BITS/32-1][31:0] cols;   // column c = bytes 4c..4c+3
    } aes_block_t;

    `include "aes_sbox.svh"

    function automatic logic [7:0] aes_rcon(input aes_round_idx_t r);
        case (r)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic [7:0] sbox(input logic [7:0] b);
        return AES_SBOX[b];
    endfunction

    // multiply by 2 in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return b[7] ? ((b << 1) ^ 8'h1b) : (b << 1);
    endfunction

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    function automatic logic [31:0] rot_word(input logic [31:0] w);
        return {w[23:0], w[31:24]};  // one byte left
    endfunction

endpackage

`default_nettype wire

/* include/aes_sbox.svh */
`ifndef AES_SBOX_SVH
`define AES_SBOX_SVH

// forward S-box, entry 0 in the top byte
localparam logic [0:255][7:0] AES_SBOX = {
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
};

`endif
